// ==== rtl/exu_isa_pkg.sv ====
`default_nettype none

package exu_isa_pkg;

  // datapath width, the word ops below depend on 64
  localparam int XLEN = 64;

  // operation codes, anything from 27 up is illegal
  typedef enum logic [4:0] {
    op_add    = 5'd0,
    op_sub    = 5'd1,
    op_addw   = 5'd2,
    op_addi   = 5'd3,
    op_addiw  = 5'd4,
    op_sltiu  = 5'd5,
    op_srai   = 5'd6,
    op_slliw  = 5'd7,
    op_divw   = 5'd8,
    op_lui    = 5'd9,
    op_auipc  = 5'd10,
    op_jal    = 5'd11,
    op_jalr   = 5'd12,
    op_beq    = 5'd13,
    op_bge    = 5'd14,
    op_ld     = 5'd15,
    op_lw     = 5'd16,
    op_lwu    = 5'd17,
    op_lh     = 5'd18,
    op_lhu    = 5'd19,
    op_lb     = 5'd20,
    op_lbu    = 5'd21,
    op_sd     = 5'd22,
    op_sw     = 5'd23,
    op_sh     = 5'd24,
    op_sb     = 5'd25,
    op_ebreak = 5'd26
  } exu_op_e;

  typedef enum logic [1:0] {
    trap_none    = 2'd0,
    trap_ebreak  = 2'd1,
    trap_illegal = 2'd2
  } exu_trap_e;

  typedef enum logic [1:0] {
    mk_none  = 2'd0,
    mk_load  = 2'd1,
    mk_store = 2'd2
  } exu_mem_kind_e;

  function automatic exu_mem_kind_e mem_kind_of(input exu_op_e op);
    case (op)
      op_ld, op_lw, op_lwu, op_lh, op_lhu, op_lb, op_lbu: return mk_load;
      op_sd, op_sw, op_sh, op_sb: return mk_store;
      default: return mk_none;
    endcase
  endfunction

  // log2 of the access size in bytes
  function automatic logic [1:0] mem_size_of(input exu_op_e op);
    case (op)
      op_ld, op_sd: return 2'd3;
      op_lw, op_lwu, op_sw: return 2'd2;
      op_lh, op_lhu, op_sh: return 2'd1;
      default: return 2'd0;
    endcase
  endfunction

endpackage

`default_nettype wire

// ==== rtl/exu_pipe_pkg.sv ====
`default_nettype none

package exu_pipe_pkg;

  import exu_isa_pkg::*;

  // one decoded operation as it enters the core
  typedef struct packed {
    exu_op_e         op;
    logic [XLEN-1:0] src1;
    logic [XLEN-1:0] src2;
    logic [XLEN-1:0] imm;
    logic [XLEN-1:0] pc;
  } exu_issue_t;

  // issue to alu
  typedef struct packed {
    exu_op_e         op;
    logic [XLEN-1:0] src1;
    logic [XLEN-1:0] src2;
    logic [XLEN-1:0] imm;
    logic [XLEN-1:0] pc;
    exu_mem_kind_e   mem_kind;
    logic [XLEN-1:0] ea;
  } exu_ex_t;

  // alu to memory
  typedef struct packed {
    exu_op_e         op;
    exu_mem_kind_e   mem_kind;
    logic [XLEN-1:0] ea;
    logic [XLEN-1:0] sdata;
    logic [XLEN-1:0] alu_res;
    logic [XLEN-1:0] dnpc;
    exu_trap_e       trap;
  } exu_mem_t;

  typedef struct packed {
    logic [XLEN-1:0] result;
    logic [XLEN-1:0] dnpc;
    exu_trap_e       trap;
  } exu_result_t;

endpackage

`default_nettype wire

// ==== rtl/exu_issue_stage.sv ====
`timescale 1ns/100ps
`default_nettype none

module exu_issue_stage
  import exu_isa_pkg::*, exu_pipe_pkg::*;
(
  input  wire logic       clk,
  input  wire logic       rst,
  input  wire logic       in_valid,
  input  wire exu_issue_t in_op,
  output logic            ex_valid,
  output exu_ex_t         ex
);

  exu_mem_kind_e   kind;
  logic [XLEN-1:0] ea_next;

  assign kind = mem_kind_of(in_op.op);

  // loads address off src2, stores off the immediate
  always_comb begin
    case (kind)
      mk_load:  ea_next = in_op.src1 + in_op.src2;
      mk_store: ea_next = in_op.src1 + in_op.imm;
      default:  ea_next = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      ex_valid <= 1'b0;
    end else begin
      ex_valid <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid) begin
      ex.op       <= in_op.op;
      ex.src1     <= in_op.src1;
      ex.src2     <= in_op.src2;
      ex.imm      <= in_op.imm;
      ex.pc       <= in_op.pc;
      ex.mem_kind <= kind;
      ex.ea       <= ea_next;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/exu_alu_stage.sv ====
`timescale 1ns/100ps
`default_nettype none

module exu_alu_stage
  import exu_isa_pkg::*, exu_pipe_pkg::*;
(
  input  wire logic    clk,
  input  wire logic    rst,
  input  wire logic    ex_valid,
  input  wire exu_ex_t ex,
  output logic         mem_valid,
  output exu_mem_t     mem
);

  logic [XLEN-1:0]   pc_plus4;
  logic [XLEN-1:0]   br_target;
  logic [31:0]       sum_w;
  logic [31:0]       sll_w;
  logic signed [31:0] dividend;
  logic signed [31:0] divisor;
  logic [31:0]       quo_w;
  logic [XLEN-1:0]   res;
  logic [XLEN-1:0]   dnpc;
  exu_trap_e         trap;

  assign pc_plus4  = ex.pc + XLEN'(4);
  assign br_target = ex.pc + ex.imm;

  // shared 32-bit sum for addw and addiw
  assign sum_w = ex.src1[31:0] + ex.src2[31:0];
  assign sll_w = ex.src1[31:0] << ex.src2[4:0];

  assign dividend = ex.src1[31:0];
  assign divisor  = ex.src2[31:0];

  // riscv rules: x/0 is all ones, min/-1 gives the dividend back
  always_comb begin
    if (divisor == 32'sd0) begin
      quo_w = '1;
    end else if (dividend == 32'sh8000_0000 && divisor == -32'sd1) begin
      quo_w = dividend;
    end else begin
      quo_w = dividend / divisor;
    end
  end

  always_comb begin
    res  = '0;
    dnpc = '0;
    trap = trap_none;
    case (ex.op)
      op_add:   res = ex.src1 + ex.src2;
      op_sub:   res = ex.src1 - ex.src2;
      op_addi:  res = ex.src1 + ex.src2;
      op_addw,
      op_addiw: res = {{32{sum_w[31]}}, sum_w};
      op_sltiu: res = XLEN'(ex.src1 < ex.src2);
      op_srai:  res = $signed(ex.src1) >>> ex.src2[5:0];
      op_slliw: res = {{32{sll_w[31]}}, sll_w};
      op_divw:  res = {{32{quo_w[31]}}, quo_w};
      op_lui:   res = ex.src1;
      op_auipc: res = ex.src1 + ex.pc;
      op_jal: begin
        res  = pc_plus4;
        dnpc = ex.pc + ex.src1;
      end
      op_jalr: begin
        res  = pc_plus4;
        dnpc = ex.src1 + ex.src2;
      end
      op_beq: begin
        dnpc = (ex.src1 == ex.src2) ? br_target : pc_plus4;
      end
      op_bge: begin
        dnpc = ($signed(ex.src1) >= $signed(ex.src2)) ? br_target : pc_plus4;
      end
      // memory ops, result comes from the next stage
      op_ld, op_lw, op_lwu, op_lh, op_lhu, op_lb, op_lbu,
      op_sd, op_sw, op_sh, op_sb: res = '0;
      op_ebreak: trap = trap_ebreak;
      default:   trap = trap_illegal;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      mem_valid <= 1'b0;
    end else begin
      mem_valid <= ex_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (ex_valid) begin
      mem.op       <= ex.op;
      mem.mem_kind <= ex.mem_kind;
      mem.ea       <= ex.ea;
      mem.sdata    <= ex.src2;
      mem.alu_res  <= res;
      mem.dnpc     <= dnpc;
      mem.trap     <= trap;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/exu_mem_stage.sv ====
`timescale 1ns/100ps
`default_nettype none

module exu_mem_stage
  import exu_isa_pkg::*, exu_pipe_pkg::*;
#(
  parameter int DMEM_WORDS = 256
) (
  input  wire logic     clk,
  input  wire logic     rst,
  input  wire logic     mem_valid,
  input  wire exu_mem_t mem,
  output logic          out_valid,
  output exu_result_t   out
);

  localparam int IDX_W = (DMEM_WORDS > 1) ? $clog2(DMEM_WORDS) : 1;

  // doubleword storage
  logic [XLEN-1:0] dmem [DMEM_WORDS];

  logic [XLEN-4:0]  word_addr;
  logic [IDX_W-1:0] idx;
  logic [2:0]       off;
  logic [7:0]       size_mask;
  logic [7:0]       st_mask;
  logic [XLEN-1:0]  st_data;
  logic [XLEN-1:0]  ld_shift;
  logic [XLEN-1:0]  ld_ext;
  logic [XLEN-1:0]  result;

  assign word_addr = mem.ea[XLEN-1:3];
  assign idx       = IDX_W'(word_addr % (XLEN-3)'(DMEM_WORDS));
  assign off       = mem.ea[2:0];

  always_comb begin
    case (mem_size_of(mem.op))
      2'd3:    size_mask = 8'hff;
      2'd2:    size_mask = 8'h0f;
      2'd1:    size_mask = 8'h03;
      default: size_mask = 8'h01;
    endcase
  end

  // bytes pushed past byte 7 fall off the 8-bit mask
  assign st_mask = size_mask << off;
  assign st_data = mem.sdata << {off, 3'b000};

  always_ff @(posedge clk) begin
    if (mem_valid && mem.mem_kind == mk_store) begin
      for (int b = 0; b < 8; b++) begin
        if (st_mask[b]) begin
          dmem[idx][8*b +: 8] <= st_data[8*b +: 8];
        end
      end
    end
  end

  // zero fill from the top, like an unaligned read of one word
  assign ld_shift = dmem[idx] >> {off, 3'b000};

  always_comb begin
    case (mem.op)
      op_ld:   ld_ext = ld_shift;
      op_lw:   ld_ext = {{32{ld_shift[31]}}, ld_shift[31:0]};
      op_lwu:  ld_ext = {32'b0, ld_shift[31:0]};
      op_lh:   ld_ext = {{48{ld_shift[15]}}, ld_shift[15:0]};
      op_lhu:  ld_ext = {48'b0, ld_shift[15:0]};
      op_lb:   ld_ext = {{56{ld_shift[7]}}, ld_shift[7:0]};
      op_lbu:  ld_ext = {56'b0, ld_shift[7:0]};
      default: ld_ext = '0;
    endcase
  end

  always_comb begin
    case (mem.mem_kind)
      mk_load:  result = ld_ext;
      mk_store: result = '0;
      default:  result = mem.alu_res;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= mem_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (mem_valid) begin
      out.result <= result;
      out.dnpc   <= mem.dnpc;
      out.trap   <= mem.trap;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/exu_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module exu_top
  import exu_pipe_pkg::*;
#(
  parameter int DMEM_WORDS = 256
) (
  input  wire logic       clk,
  input  wire logic       rst,
  input  wire logic       in_valid,
  input  wire exu_issue_t in_op,
  output logic            out_valid,
  output exu_result_t     out
);

  // stage-to-stage strobes and bundles
  logic     ex_valid;
  exu_ex_t  ex;
  logic     mem_valid;
  exu_mem_t mem;

  exu_issue_stage u_issue (
    .clk      (clk),
    .rst      (rst),
    .in_valid (in_valid),
    .in_op    (in_op),
    .ex_valid (ex_valid),
    .ex       (ex)
  );

  exu_alu_stage u_alu (
    .clk       (clk),
    .rst       (rst),
    .ex_valid  (ex_valid),
    .ex        (ex),
    .mem_valid (mem_valid),
    .mem       (mem)
  );

  // holds the data memory
  exu_mem_stage #(
    .DMEM_WORDS (DMEM_WORDS)
  ) u_mem (
    .clk       (clk),
    .rst       (rst),
    .mem_valid (mem_valid),
    .mem       (mem),
    .out_valid (out_valid),
    .out       (out)
  );

endmodule

`default_nettype wire

// ==== tb/exu_props.sv ====
`timescale 1ns/100ps
`default_nettype none

module exu_props (
  input wire logic clk,
  input wire logic rst,
  input wire logic in_valid,
  input wire logic out_valid
);

  int fail_count = 0;

  // fixed three-stage latency
  issue_to_result: assert property (
    @(posedge clk) disable iff (rst) in_valid |-> ##3 out_valid
  ) else begin
    fail_count++;
    $error("out_valid not high three cycles after in_valid");
  end

  // no result without an issue three cycles back
  result_has_issue: assert property (
    @(posedge clk) disable iff (rst) out_valid |-> $past(in_valid, 3)
  ) else begin
    fail_count++;
    $error("out_valid high without an issue three cycles before");
  end

  // covers every reset cycle and the one right after
  quiet_in_reset: assert property (@(posedge clk) rst |=> !out_valid)
  else begin
    fail_count++;
    $error("out_valid high during or right after reset");
  end

endmodule

bind exu_top exu_props props0 (
  .clk       (clk),
  .rst       (rst),
  .in_valid  (in_valid),
  .out_valid (out_valid)
);

`default_nettype wire

// ==== tb/exu_checker.sv ====
`timescale 1ns/100ps
`default_nettype none

module exu_checker
  import exu_isa_pkg::*, exu_pipe_pkg::*;
#(
  parameter int DMEM_WORDS = 256
) (
  input  wire logic         clk,
  input  wire logic         rst,
  input  wire logic         in_valid,
  input  wire exu_issue_t   in_op,
  input  wire logic [127:0] name,
  input  wire logic         use_model,
  input  wire exu_result_t  exp_in,
  input  wire logic         out_valid,
  input  wire exu_result_t  out,
  output int                errors,
  output int                checks,
  output int                pending
);

  typedef struct packed {
    logic [127:0] name;
    exu_result_t  exp;
  } entry_t;

  entry_t     expq[$];
  logic [7:0] mem_bytes [DMEM_WORDS*8];

  function automatic int access_bytes(input exu_op_e op);
    case (op)
      op_ld, op_sd: return 8;
      op_lw, op_lwu, op_sw: return 4;
      op_lh, op_lhu, op_sh: return 2;
      default: return 1;
    endcase
  endfunction

  // byte-array memory model plus add and sub
  task automatic predict(input exu_issue_t op, output exu_result_t r);
    logic [63:0] ea;
    logic [63:0] v;
    int base;
    int off;
    int n;
    r = '0;
    n = access_bytes(op.op);
    ea = (op.op inside {op_sd, op_sw, op_sh, op_sb}) ? op.src1 + op.imm : op.src1 + op.src2;
    base = int'((ea >> 3) % DMEM_WORDS) * 8;
    off = int'(ea[2:0]);
    case (op.op)
      op_add: r.result = op.src1 + op.src2;
      op_sub: r.result = op.src1 - op.src2;
      op_sd, op_sw, op_sh, op_sb: begin
        // bytes past the doubleword end are lost
        for (int k = 0; k < n && off + k < 8; k++) begin
          mem_bytes[base + off + k] = op.src2[8*k +: 8];
        end
      end
      op_ld, op_lw, op_lwu, op_lh, op_lhu, op_lb, op_lbu: begin
        v = '0;
        for (int k = off; k < 8; k++) begin
          v[8*(k-off) +: 8] = mem_bytes[base + k];
        end
        case (op.op)
          op_lw:   r.result = {{32{v[31]}}, v[31:0]};
          op_lwu:  r.result = {32'b0, v[31:0]};
          op_lh:   r.result = {{48{v[15]}}, v[15:0]};
          op_lhu:  r.result = {48'b0, v[15:0]};
          op_lb:   r.result = {{56{v[7]}}, v[7:0]};
          op_lbu:  r.result = {56'b0, v[7:0]};
          default: r.result = v;
        endcase
      end
      default: r.result = '0;
    endcase
  endtask

  initial begin
    errors = 0;
    checks = 0;
    pending = 0;
  end

  // sampled mid-cycle away from both edges
  always @(negedge clk) begin
    entry_t      e;
    exu_result_t r;
    if (!rst) begin
      if (out_valid) begin
        if (expq.size() == 0) begin
          $display("result came out with no operation outstanding");
          errors++;
        end else begin
          e = expq.pop_front();
          checks++;
          if (out !== e.exp) begin
            $display(
              "CHECK FAILED %0s: expected res %h npc %h trap %0d, actual res %h npc %h trap %0d",
              e.name, e.exp.result, e.exp.dnpc, e.exp.trap,
              out.result, out.dnpc, out.trap);
            errors++;
          end
        end
      end
      if (in_valid) begin
        if (use_model) begin
          predict(in_op, r);
        end else begin
          r = exp_in;
        end
        e.name = name;
        e.exp = r;
        expq.push_back(e);
      end
      pending = expq.size();
    end
  end

endmodule

`default_nettype wire

// ==== tb/tb_exu.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_exu
  import exu_isa_pkg::*, exu_pipe_pkg::*;
();

  localparam int          DMEM_WORDS = 256;
  localparam logic [31:0] SEED       = 32'hf1fd6ac1;

  typedef struct packed {
    logic [127:0] name;
    logic         burst;
    logic         use_model;
    exu_issue_t   op;
    exu_result_t  exp;
  } test_t;

  logic         clk;
  logic         rst;
  logic         in_valid;
  exu_issue_t   in_op;
  logic         out_valid;
  exu_result_t  out;
  logic [127:0] cur_name;
  logic         cur_model;
  exu_result_t  cur_exp;
  int           errors;
  int           checks;
  int           pending;
  test_t        tests[$];
  logic         burst_mode;
  logic [31:0]  lfsr_state;

  exu_top #(
    .DMEM_WORDS (DMEM_WORDS)
  ) dut0 (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .in_op     (in_op),
    .out_valid (out_valid),
    .out       (out)
  );

  exu_checker #(
    .DMEM_WORDS (DMEM_WORDS)
  ) chk0 (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .in_op     (in_op),
    .name      (cur_name),
    .use_model (cur_model),
    .exp_in    (cur_exp),
    .out_valid (out_valid),
    .out       (out),
    .errors    (errors),
    .checks    (checks),
    .pending   (pending)
  );

  initial clk = 1'b0;
  always #20 clk = ~clk;

  // taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic take_bits(input int n, output logic [63:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      v = {v[62:0], lfsr_state[0]};
    end
  endtask

  task automatic push_fixed(input logic [127:0] name, input exu_op_e op,
                            input logic [63:0] s1, s2, imm, pc, res, dnpc,
                            input exu_trap_e trap);
    test_t t;
    t.name = name;
    t.burst = burst_mode;
    t.use_model = 1'b0;
    t.op = '{op, s1, s2, imm, pc};
    t.exp = '{res, dnpc, trap};
    tests.push_back(t);
  endtask

  task automatic push_alu(input logic [127:0] name, input exu_op_e op,
                          input logic [63:0] s1, s2, res);
    push_fixed(name, op, s1, s2, 0, 0, res, 0, trap_none);
  endtask

  // expected value filled in by the checker model
  task automatic push_model(input logic [127:0] name, input exu_op_e op,
                            input logic [63:0] s1, s2, imm);
    test_t t;
    t.name = name;
    t.burst = burst_mode;
    t.use_model = 1'b1;
    t.op = '{op, s1, s2, imm, 64'h0};
    t.exp = '0;
    tests.push_back(t);
  endtask

  task automatic build_table();
    logic [63:0] a;
    logic [63:0] b;
    burst_mode = 1'b0;
    push_alu("add_ovf", op_add, 64'h7fffffffffffffff, 1, 64'h8000000000000000);
    push_alu("sub_neg", op_sub, 5, 7, -64'd2);
    push_alu("addi_neg", op_addi, 100, -64'd3, 97);
    push_alu("addw_ovf", op_addw, 64'h7fffffff, 1, 64'hffffffff80000000);
    push_alu("addiw_wrap", op_addiw, 64'h12345678ffffffff, 2, 1);
    push_alu("sltiu_lt", op_sltiu, 3, -64'd1, 1);
    push_alu("sltiu_ge", op_sltiu, -64'd1, 3, 0);
    push_alu("srai_neg", op_srai, 64'h8000000000000000, 4, 64'hf800000000000000);
    push_alu("srai_mod64", op_srai, -64'd16, 64'h43, -64'd2);
    push_alu("slliw_sign", op_slliw, 1, 31, 64'hffffffff80000000);
    push_alu("slliw_mod32", op_slliw, 3, 33, 6);
    push_alu("divw_neg", op_divw, -64'd7, 2, -64'd3);
    push_alu("divw_hi_bits", op_divw, 64'haaaaaaaa00000064, 7, 14);
    push_alu("divw_zero", op_divw, 5, 0, -64'd1);
    push_alu("divw_ovf", op_divw, 64'h80000000, -64'd1, 64'hffffffff80000000);
    push_alu("lui", op_lui, 64'hffffffff87654000, 0, 64'hffffffff87654000);
    push_fixed("auipc", op_auipc, 64'h1000, 0, 0, 64'h80000000, 64'h80001000, 0, trap_none);
    push_fixed("jal", op_jal, 64'h20, 0, 0, 64'h80000100, 64'h80000104, 64'h80000120,
               trap_none);
    push_fixed("jalr", op_jalr, 64'h80002000, 64'h10, 0, 64'h80000200, 64'h80000204,
               64'h80002010, trap_none);
    push_fixed("beq_taken", op_beq, 64'h55, 64'h55, -64'd8, 64'h80000300, 0, 64'h800002f8,
               trap_none);
    push_fixed("beq_not", op_beq, 1, 2, 64'h40, 64'h80000300, 0, 64'h80000304, trap_none);
    push_fixed("bge_taken", op_bge, 1, -64'd1, 64'h10, 64'h400, 0, 64'h410, trap_none);
    push_fixed("bge_not", op_bge, -64'd2, 1, 64'h10, 64'h400, 0, 64'h404, trap_none);
    push_fixed("bge_equal", op_bge, -64'd5, -64'd5, 64'h10, 64'h400, 0, 64'h410, trap_none);
    push_fixed("ebreak", op_ebreak, 1, 2, 3, 64'h500, 0, 0, trap_ebreak);
    push_fixed("illegal", exu_op_e'(5'd30), 1, 2, 3, 64'h504, 0, 0, trap_illegal);
    // memory section goes out back to back
    burst_mode = 1'b1;
    push_model("sd_w0", op_sd, 64'h100, 64'h0011223344556677, 0);
    push_model("sd_w1", op_sd, 64'h100, 64'h8899aabbccddeeff, 8);
    push_model("sd_off3", op_sd, 64'h100, 64'h0123456789abcdef, 11);
    push_model("sw_off5", op_sw, 64'h100, 64'h11112222a1b2c3d4, 5);
    push_model("sh_off2", op_sh, 64'h100, 64'hbeef, 2);
    push_model("sb_off1", op_sb, 64'h108, 64'h80, 1);
    push_model("sh_off7", op_sh, 64'h108, 64'h7f01, 7);
    push_model("ld_off0", op_ld, 64'h100, 0, 0);
    push_model("ld_off3", op_ld, 64'h100, 3, 0);
    push_model("ld_w1_off0", op_ld, 64'h108, 0, 0);
    push_model("lw_off4", op_lw, 64'h100, 4, 0);
    push_model("lwu_off4", op_lwu, 64'h100, 4, 0);
    push_model("lw_off6", op_lw, 64'h100, 6, 0);
    push_model("lh_off2", op_lh, 64'h100, 2, 0);
    push_model("lhu_off2", op_lhu, 64'h100, 2, 0);
    push_model("lb_off1", op_lb, 64'h108, 1, 0);
    push_model("lbu_off1", op_lbu, 64'h108, 1, 0);
    push_model("lb_off7", op_lb, 64'h108, 7, 0);
    // load on the cycle right after the store
    push_model("sd_raw", op_sd, 64'h200, 64'hcafef00d12345678, 0);
    push_model("ld_raw", op_ld, 64'h1f8, 8, 0);
    // doubleword 256 wraps onto doubleword 0
    push_model("sd_wrap", op_sd, 64'h800, 64'h0102030405060708, 0);
    push_model("ld_alias", op_ld, 0, 0, 0);
    burst_mode = 1'b0;
    for (int i = 0; i < 6; i++) begin
      take_bits(64, a);
      take_bits(64, b);
      push_model("rand_addsub", (i % 2) ? op_sub : op_add, a, b, 0);
    end
  endtask

  initial begin
    logic [63:0] gap;
    rst = 1'b1;
    in_valid = 1'b0;
    in_op = '0;
    cur_name = '0;
    cur_model = 1'b0;
    cur_exp = '0;
    lfsr_state = SEED;
    build_table();
    repeat (16) @(posedge clk);
    #2;
    rst = 1'b0;
    foreach (tests[i]) begin
      take_bits(1, gap);
      if (!tests[i].burst && gap[0]) begin
        in_valid = 1'b0;
        @(posedge clk);
        #2;
      end
      in_valid = 1'b1;
      in_op = tests[i].op;
      cur_name = tests[i].name;
      cur_model = tests[i].use_model;
      cur_exp = tests[i].exp;
      @(posedge clk);
      #2;
    end
    in_valid = 1'b0;
    wait (pending == 0);
    repeat (4) @(posedge clk);
    $display("%0d checks, %0d errors, %0d assertion failures",
             checks, errors, dut0.props0.fail_count);
    if (errors == 0 && checks == tests.size() && dut0.props0.fail_count == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

  // watchdog
  initial begin
    @(negedge rst);
    repeat (tests.size() * 2 + 100) @(posedge clk);
    $display("timeout: %0d results still missing", pending);
    $display("Testbench failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb.f ====
rtl/exu_isa_pkg.sv
rtl/exu_pipe_pkg.sv
rtl/exu_issue_stage.sv
rtl/exu_alu_stage.sv
rtl/exu_mem_stage.sv
rtl/exu_top.sv
tb/exu_props.sv
tb/exu_checker.sv
tb/tb_exu.sv
